// File: build.f
logic/lookup_pkg.sv
logic/action_ram.sv
logic/tcam_table.sv
logic/lookup_ctrl.sv
logic/table_config.sv
logic/lookup_engine.sv
+incdir+sim
sim/tb_lookup_engine.sv

// File: logic/action_ram.sv
// 16-entry action memory, one write port and one registered read port.
// rd_action updates the cycle after an enabled read and holds otherwise.

`timescale 1ns/1ps

module action_ram (
    input  logic                                 clk,
    input  lookup_pkg::act_wr_t                  act_wr,
    input  logic                                 rd_en,
    input  logic [lookup_pkg::TABLE_ADDR_W-1:0]  rd_addr,
    output logic [lookup_pkg::ACT_W-1:0]         rd_action
);

    // table starts out all zeros
    logic [lookup_pkg::ACT_W-1:0] mem [lookup_pkg::TABLE_DEPTH] = '{default: '0};

    always_ff @(posedge clk) begin
        if (act_wr.en) begin
            mem[act_wr.addr] <= act_wr.data;
        end
    end

    // read before write on an address collision
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_action <= mem[rd_addr];
        end
    end

endmodule

// File: logic/lookup_ctrl.sv
// Sequences one lookup at a time.
// A key taken in cycle 0 returns the default action in cycle 2 on a miss,
// or the stored action in cycle 4 on a hit, with the PHV latched at cycle 0.
// Keys arriving while busy are dropped.

`timescale 1ns/1ps

module lookup_ctrl (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         key_valid,
    input  logic [lookup_pkg::PHV_W-1:0] phv_in,
    input  lookup_pkg::match_t           match,
    input  logic [lookup_pkg::ACT_W-1:0] rd_action,
    output logic [lookup_pkg::ACT_W-1:0] action,
    output logic                         action_valid,
    output logic [lookup_pkg::PHV_W-1:0] phv_out,
    output logic                         cmp_en
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_COMPARE,
        ST_READ,
        ST_RETURN
    } state_t;

    state_t                       state;
    logic [lookup_pkg::PHV_W-1:0] phv_q;
    logic                         emit_miss;
    logic                         emit_hit;

    assign cmp_en    = key_valid && (state == ST_IDLE);
    assign emit_miss = (state == ST_COMPARE) && !match.hit;
    assign emit_hit  = (state == ST_RETURN);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= ST_IDLE;
            action_valid <= 1'b0;
        end else begin
            action_valid <= emit_miss || emit_hit;
            case (state)
                ST_IDLE: begin
                    if (cmp_en) begin
                        state <= ST_COMPARE;
                    end
                end
                ST_COMPARE: state <= match.hit ? ST_READ : ST_IDLE;
                // memory output lands during this state
                ST_READ:    state <= ST_RETURN;
                ST_RETURN:  state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmp_en) begin
            phv_q <= phv_in;
        end
        if (emit_miss) begin
            action <= lookup_pkg::DEFAULT_ACTION;
        end else if (emit_hit) begin
            action <= rd_action;
        end
        if (emit_miss || emit_hit) begin
            phv_out <= phv_q;
        end
    end

endmodule

// File: logic/lookup_engine.sv
// One match-action lookup stage.
// Keys are matched against a 16-entry key table; a hit returns the stored
// action, a miss the default action. The control stream fills both tables
// and passes packets for other stages through.

`timescale 1ns/1ps

module lookup_engine #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd2
) (
    input  logic                         clk,
    input  logic                         rst_n,

    input  logic [lookup_pkg::KEY_W-1:0] extract_key,
    input  logic [lookup_pkg::KEY_W-1:0] extract_mask,
    input  logic                         key_valid,
    input  logic [lookup_pkg::PHV_W-1:0] phv_in,

    output logic [lookup_pkg::ACT_W-1:0] action,
    output logic                         action_valid,
    output logic [lookup_pkg::PHV_W-1:0] phv_out,

    input  lookup_pkg::ctrl_beat_t       c_s,
    output lookup_pkg::ctrl_beat_t       c_m
);

    lookup_pkg::match_t          match;
    lookup_pkg::key_wr_t         key_wr;
    lookup_pkg::act_wr_t         act_wr;
    logic [lookup_pkg::ACT_W-1:0] rd_action;
    logic                         cmp_en;

    lookup_ctrl u_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .match        (match),
        .rd_action    (rd_action),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .cmp_en       (cmp_en)
    );

    tcam_table u_tcam_table (
        .clk      (clk),
        .rst_n    (rst_n),
        .key_wr   (key_wr),
        .cmp_key  (extract_key),
        .cmp_mask (extract_mask),
        .cmp_en   (cmp_en),
        .match    (match)
    );

    // read side follows the registered match result
    action_ram u_action_ram (
        .clk       (clk),
        .act_wr    (act_wr),
        .rd_en     (match.hit),
        .rd_addr   (match.addr),
        .rd_action (rd_action)
    );

    table_config #(
        .STAGE_ID  (STAGE_ID),
        .LOOKUP_ID (LOOKUP_ID)
    ) u_table_config (
        .clk    (clk),
        .rst_n  (rst_n),
        .c_s    (c_s),
        .c_m    (c_m),
        .key_wr (key_wr),
        .act_wr (act_wr)
    );

endmodule

// File: logic/lookup_pkg.sv
// Shared widths, constants and bus types for the match-action lookup stage.
// Compile this first. Other files refer to it through lookup_pkg:: names.
package lookup_pkg;

    // lookup datapath
    localparam int KEY_W = 197;
    localparam int ACT_W = 625;
    localparam int PHV_W = 1124;

    // control stream
    localparam int DATA_W = 512;
    localparam int KEEP_W = 64;
    localparam int USER_W = 128;

    localparam int TABLE_DEPTH  = 16;
    localparam int TABLE_ADDR_W = 4;

    localparam logic [15:0] CTRL_FLAG     = 16'hf2f1;
    localparam logic [3:0]  SEL_KEY_TABLE = 4'h0;

    // returned on a miss
    localparam logic [ACT_W-1:0] DEFAULT_ACTION = ACT_W'('h3f);

    // action entry split over two payload beats
    localparam int ACT_HI_W = 512;
    localparam int ACT_LO_W = 113;

    typedef struct packed {
        logic [DATA_W-1:0] tdata;
        logic [USER_W-1:0] tuser;
        logic [KEEP_W-1:0] tkeep;
        logic              tvalid;
        logic              tlast;
    } ctrl_beat_t;

    typedef struct packed {
        logic [4:0] stage;
        logic [2:0] lookup;
    } mod_id_t;

    // header beat layout from the msb down
    typedef struct packed {
        logic [119:0] rsvd_hi;
        logic [7:0]   index;
        logic [3:0]   tsel;
        logic [3:0]   rsvd_a;
        mod_id_t      mod_id;
        logic [31:0]  rsvd_b;
        logic [15:0]  flag;
        logic [319:0] rsvd_lo;
    } ctrl_hdr_t;

    typedef union packed {
        logic [DATA_W-1:0] raw;
        ctrl_hdr_t         hdr;
    } ctrl_word_u;

    typedef struct packed {
        logic                    en;
        logic [TABLE_ADDR_W-1:0] addr;
        logic [KEY_W-1:0]        data;
    } key_wr_t;

    typedef struct packed {
        logic                    en;
        logic [TABLE_ADDR_W-1:0] addr;
        logic [ACT_W-1:0]        data;
    } act_wr_t;

    typedef struct packed {
        logic                    hit;
        logic [TABLE_ADDR_W-1:0] addr;
    } match_t;

endpackage

// File: logic/table_config.sv
// Control-stream parser beside the key and action tables.
// The header beat decides once per packet whether to forward it, write key
// entries or write action entries. Payload beats are byte-reversed first.
// Foreign packets leave on c_m one cycle later, unchanged.

`timescale 1ns/1ps

module table_config #(
    parameter logic [4:0] STAGE_ID  = 5'd0,
    parameter logic [2:0] LOOKUP_ID = 3'd2
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  lookup_pkg::ctrl_beat_t c_s,
    output lookup_pkg::ctrl_beat_t c_m,
    output lookup_pkg::key_wr_t    key_wr,
    output lookup_pkg::act_wr_t    act_wr
);

    localparam int DATA_W = lookup_pkg::DATA_W;
    localparam int ADDR_W = lookup_pkg::TABLE_ADDR_W;
    localparam int BYTES  = lookup_pkg::KEEP_W;

    typedef enum logic [1:0] {
        MODE_HDR,
        MODE_FWD,
        MODE_KEY,
        MODE_ACT
    } mode_t;

    lookup_pkg::ctrl_word_u          word;
    logic [DATA_W-1:0]               swapped;
    logic                            for_us;
    logic                            fwd_beat;
    mode_t                           mode;
    logic [ADDR_W-1:0]               wr_addr;
    logic                            half;
    logic [lookup_pkg::ACT_HI_W-1:0] act_hi;

    assign word.raw = c_s.tdata;

    // byte i takes byte 63-i
    always_comb begin
        for (int i = 0; i < BYTES; i++) begin
            swapped[8*i +: 8] = word.raw[8*(BYTES-1-i) +: 8];
        end
    end

    assign for_us = (word.hdr.flag == lookup_pkg::CTRL_FLAG)
                 && (word.hdr.mod_id.stage == STAGE_ID)
                 && (word.hdr.mod_id.lookup == LOOKUP_ID);

    assign fwd_beat = c_s.tvalid
                   && ((mode == MODE_FWD) || ((mode == MODE_HDR) && !for_us));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode    <= MODE_HDR;
            wr_addr <= '0;
            half    <= 1'b0;
            c_m     <= '0;
            key_wr  <= '0;
            act_wr  <= '0;
        end else begin
            if (fwd_beat) begin
                c_m <= c_s;
            end else begin
                c_m.tvalid <= 1'b0;
            end
            key_wr.en <= 1'b0;
            act_wr.en <= 1'b0;

            if (c_s.tvalid) begin
                case (mode)
                    MODE_HDR: begin
                        wr_addr <= word.hdr.index[ADDR_W-1:0];
                        half    <= 1'b0;
                        if (c_s.tlast) begin
                            mode <= MODE_HDR;
                        end else if (!for_us) begin
                            mode <= MODE_FWD;
                        end else if (word.hdr.tsel == lookup_pkg::SEL_KEY_TABLE) begin
                            mode <= MODE_KEY;
                        end else begin
                            mode <= MODE_ACT;
                        end
                    end
                    MODE_FWD: begin
                        if (c_s.tlast) begin
                            mode <= MODE_HDR;
                        end
                    end
                    MODE_KEY: begin
                        key_wr.en   <= 1'b1;
                        key_wr.addr <= wr_addr;
                        key_wr.data <= swapped[DATA_W-1 -: lookup_pkg::KEY_W];
                        wr_addr     <= wr_addr + 1'b1;
                        if (c_s.tlast) begin
                            mode <= MODE_HDR;
                        end
                    end
                    MODE_ACT: begin
                        // second beat of a pair completes the entry
                        if (half) begin
                            act_wr.en   <= 1'b1;
                            act_wr.addr <= wr_addr;
                            act_wr.data <= {act_hi, swapped[DATA_W-1 -: lookup_pkg::ACT_LO_W]};
                            wr_addr     <= wr_addr + 1'b1;
                        end
                        half <= !half;
                        // a lone first half at tlast is dropped
                        if (c_s.tlast) begin
                            mode <= MODE_HDR;
                            half <= 1'b0;
                        end
                    end
                    default: mode <= MODE_HDR;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (c_s.tvalid && (mode == MODE_ACT) && !half) begin
            act_hi <= swapped;
        end
    end

endmodule

// File: logic/tcam_table.sv
// 16-entry key store with masked parallel compare.
// Mask bit 1 is don't care. The lowest matching index wins and the result
// is registered, so it is valid the cycle after cmp_en.

`timescale 1ns/1ps

module tcam_table (
    input  logic                         clk,
    input  logic                         rst_n,
    input  lookup_pkg::key_wr_t          key_wr,
    input  logic [lookup_pkg::KEY_W-1:0] cmp_key,
    input  logic [lookup_pkg::KEY_W-1:0] cmp_mask,
    input  logic                         cmp_en,
    output lookup_pkg::match_t           match
);

    localparam int ADDR_W = lookup_pkg::TABLE_ADDR_W;
    localparam int DEPTH  = lookup_pkg::TABLE_DEPTH;

    logic [lookup_pkg::KEY_W-1:0] keys [DEPTH];
    logic [DEPTH-1:0]             written;
    logic [DEPTH-1:0]             line_hit;
    logic                         any_hit;
    logic [ADDR_W-1:0]            first_addr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            written <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                keys[i] <= '0;
            end
        end else if (key_wr.en) begin
            keys[key_wr.addr]    <= key_wr.data;
            written[key_wr.addr] <= 1'b1;
        end
    end

    // unwritten entries never match
    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            line_hit[i] = written[i] && (((keys[i] ^ cmp_key) & ~cmp_mask) == '0);
        end
    end

    always_comb begin
        any_hit    = |line_hit;
        first_addr = '0;
        for (int i = DEPTH - 1; i >= 0; i--) begin
            if (line_hit[i]) begin
                first_addr = ADDR_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            match <= '0;
        end else if (cmp_en) begin
            match.hit  <= any_hit;
            match.addr <= first_addr;
        end else begin
            match.hit <= 1'b0;
        end
    end

endmodule

// File: sim/tb_lookup_model.svh
// Reference model for the lookup stage testbench.
// Mirrors both tables, predicts lookup results and holds the random source
// and the value check. Included inside the testbench module.
`ifndef TB_LOOKUP_MODEL_SVH
`define TB_LOOKUP_MODEL_SVH

typedef struct packed {
    logic [31:0]                  cyc;
    logic [lookup_pkg::ACT_W-1:0] action;
    logic [lookup_pkg::PHV_W-1:0] phv;
} exp_result_t;

typedef struct packed {
    logic [31:0]            cyc;
    lookup_pkg::ctrl_beat_t beat;
} exp_beat_t;

logic [lookup_pkg::KEY_W-1:0] model_keys [16];
logic [lookup_pkg::ACT_W-1:0] model_acts [16];
logic [15:0]                  model_written;
logic [31:0]                  rng_state;
int                           error_count;
exp_result_t                  result_q [$];
exp_beat_t                    beat_q [$];

// returns {hit, action} of the lowest written entry equal to the key on unmasked bits
function automatic logic [lookup_pkg::ACT_W:0] expect_lookup(
    input logic [lookup_pkg::KEY_W-1:0] key,
    input logic [lookup_pkg::KEY_W-1:0] mask
);
    logic [lookup_pkg::ACT_W:0] res;
    res = {1'b0, lookup_pkg::DEFAULT_ACTION};
    for (int i = 15; i >= 0; i--) begin
        if (model_written[i] && ((model_keys[i] & ~mask) == (key & ~mask))) begin
            res = {1'b1, model_acts[i]};
        end
    end
    return res;
endfunction

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
endfunction

task automatic check_value(input logic [1279:0] got, input logic [1279:0] exp,
                           input string what);
    if (got !== exp) begin
        error_count++;
        $display("MISMATCH at %0t: %s, got %0h, expected %0h", $time, what, got, exp);
    end
endtask

`endif

// File: sim/tb_lookup_engine.sv
// Testbench for the lookup stage.
// Fills both tables over the control stream, runs lookups and foreign
// packets, and checks every action and forwarded beat against the model.

`timescale 1ns/1ps

module tb_lookup_engine;

    localparam int KEY_W           = lookup_pkg::KEY_W;
    localparam int ACT_W           = lookup_pkg::ACT_W;
    localparam int PHV_W           = lookup_pkg::PHV_W;
    localparam int CLK_PERIOD      = 100;
    localparam int RANDOM_OPS      = 40;
    // directed and random operations each take well under 20 cycles
    localparam int TEST_OPS        = RANDOM_OPS + 60;
    localparam int WATCHDOG_CYCLES = TEST_OPS * 20;

    logic                   clk;
    logic                   rst_n;
    logic [KEY_W-1:0]       extract_key;
    logic [KEY_W-1:0]       extract_mask;
    logic                   key_valid;
    logic [PHV_W-1:0]       phv_in;
    logic [ACT_W-1:0]       action;
    logic                   action_valid;
    logic [PHV_W-1:0]       phv_out;
    lookup_pkg::ctrl_beat_t c_s;
    lookup_pkg::ctrl_beat_t c_m;
    logic [31:0]            cyc = 0;
    logic [511:0]           pkt_q [$];

    `include "tb_lookup_model.svh"

    lookup_engine #(
        .STAGE_ID  (5'd3),
        .LOOKUP_ID (3'd2)
    ) u_lookup_engine (
        .clk          (clk),
        .rst_n        (rst_n),
        .extract_key  (extract_key),
        .extract_mask (extract_mask),
        .key_valid    (key_valid),
        .phv_in       (phv_in),
        .action       (action),
        .action_valid (action_valid),
        .phv_out      (phv_out),
        .c_s          (c_s),
        .c_m          (c_m)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic logic [1279:0] rand_wide();
        logic [1279:0] v;
        for (int i = 0; i < 40; i++) begin
            v[32*i +: 32] = next_rand();
        end
        return v;
    endfunction

    // byte i of the result is byte 63-i of the word
    function automatic logic [511:0] byte_reverse(input logic [511:0] w);
        logic [511:0] r;
        for (int i = 0; i < 64; i++) begin
            r[8*i +: 8] = w[8*(63-i) +: 8];
        end
        return r;
    endfunction

    function automatic logic [511:0] make_header(input logic [4:0] stage,
                                                 input logic [2:0] lkp,
                                                 input logic [15:0] flag,
                                                 input logic [3:0] tsel,
                                                 input logic [7:0] index);
        lookup_pkg::ctrl_word_u w;
        logic [1279:0]          fill;
        fill = rand_wide();
        w.raw               = fill[511:0];
        w.hdr.flag          = flag;
        w.hdr.mod_id.stage  = stage;
        w.hdr.mod_id.lookup = lkp;
        w.hdr.tsel          = tsel;
        w.hdr.index         = index;
        return w.raw;
    endfunction

    task automatic send_packet(input logic forward);
        lookup_pkg::ctrl_beat_t b;
        exp_beat_t              e;
        logic [1279:0]          fill;
        for (int i = 0; i < pkt_q.size(); i++) begin
            @(posedge clk);
            if (i > 0 && (next_rand() % 8) == 0) begin
                c_s.tvalid <= 1'b0;
                @(posedge clk);
            end
            fill     = rand_wide();
            b.tdata  = pkt_q[i];
            b.tuser  = fill[127:0];
            b.tkeep  = fill[191:128];
            b.tvalid = 1'b1;
            b.tlast  = (i == pkt_q.size() - 1);
            c_s <= b;
            if (forward) begin
                e.cyc  = cyc + 2;
                e.beat = b;
                beat_q.push_back(e);
            end
        end
        @(posedge clk);
        c_s.tvalid <= 1'b0;
        // let the last table write land
        repeat (2) @(posedge clk);
        pkt_q.delete();
    endtask

    task automatic write_keys(input logic [7:0] index, input int count);
        logic [1279:0]    fill;
        logic [KEY_W-1:0] key;
        pkt_q.push_back(make_header(5'd3, 3'd2, lookup_pkg::CTRL_FLAG,
                                    lookup_pkg::SEL_KEY_TABLE, index));
        for (int i = 0; i < count; i++) begin
            fill = rand_wide();
            key  = fill[KEY_W-1:0];
            pkt_q.push_back(byte_reverse({key, fill[511:KEY_W]}));
            model_keys[(index + i) % 16]    = key;
            model_written[(index + i) % 16] = 1'b1;
        end
        send_packet(1'b0);
    endtask

    task automatic write_actions(input logic [7:0] index, input int pairs, input logic odd);
        logic [1279:0]    fill;
        logic [ACT_W-1:0] act;
        pkt_q.push_back(make_header(5'd3, 3'd2, lookup_pkg::CTRL_FLAG, 4'h1, index));
        for (int i = 0; i < pairs; i++) begin
            fill = rand_wide();
            act  = fill[ACT_W-1:0];
            pkt_q.push_back(byte_reverse(act[ACT_W-1 -: lookup_pkg::ACT_HI_W]));
            pkt_q.push_back(byte_reverse({act[lookup_pkg::ACT_LO_W-1:0], fill[1279 -: 399]}));
            model_acts[(index + i) % 16] = act;
        end
        if (odd) begin
            fill = rand_wide();
            pkt_q.push_back(fill[511:0]);
        end
        send_packet(1'b0);
    endtask

    // kind 0 wrong stage, 1 wrong lookup, 2 wrong flag
    task automatic send_foreign(input int kind, input int beats);
        logic [1279:0] fill;
        logic [4:0]    stage;
        logic [2:0]    lkp;
        logic [15:0]   flag;
        stage = (kind == 0) ? 5'd4 : 5'd3;
        lkp   = (kind == 1) ? 3'd5 : 3'd2;
        flag  = (kind == 2) ? 16'hf2f0 : lookup_pkg::CTRL_FLAG;
        pkt_q.push_back(make_header(stage, lkp, flag, lookup_pkg::SEL_KEY_TABLE, 8'd0));
        for (int i = 1; i < beats; i++) begin
            fill = rand_wide();
            pkt_q.push_back(fill[511:0]);
        end
        send_packet(1'b1);
    endtask

    task automatic do_lookup(input logic [KEY_W-1:0] key, input logic [KEY_W-1:0] mask);
        logic [ACT_W:0]  res;
        logic [1279:0]   fill;
        exp_result_t     e;
        logic [31:0]     t0;
        fill = rand_wide();
        @(posedge clk);
        t0 = cyc;
        extract_key  <= key;
        extract_mask <= mask;
        phv_in       <= fill[PHV_W-1:0];
        key_valid    <= 1'b1;
        res      = expect_lookup(key, mask);
        e.cyc    = res[ACT_W] ? t0 + 5 : t0 + 3;
        e.action = res[ACT_W-1:0];
        e.phv    = fill[PHV_W-1:0];
        result_q.push_back(e);
        @(posedge clk);
        key_valid <= 1'b0;
        // result back and at least 6 cycles between keys
        while (result_q.size() != 0 || cyc < t0 + 6) begin
            @(posedge clk);
        end
    endtask

    always @(negedge clk) begin : monitor
        exp_result_t er;
        exp_beat_t   eb;
        if (rst_n) begin
            if (action_valid) begin
                if (result_q.size() == 0) begin
                    error_count++;
                    $display("ERROR at %0t: action_valid with no lookup outstanding", $time);
                end else begin
                    er = result_q.pop_front();
                    check_value(cyc, er.cyc, "action_valid cycle");
                    check_value(action, er.action, "action");
                    check_value(phv_out, er.phv, "phv_out");
                end
            end else if (result_q.size() != 0) begin
                er = result_q[0];
                if (er.cyc < cyc) begin
                    error_count++;
                    $display("ERROR at %0t: lookup result did not arrive in time", $time);
                    void'(result_q.pop_front());
                end
            end
            if (c_m.tvalid) begin
                if (beat_q.size() == 0) begin
                    error_count++;
                    $display("ERROR at %0t: beat on c_m that should not be forwarded", $time);
                end else begin
                    eb = beat_q.pop_front();
                    check_value(cyc, eb.cyc, "forwarded beat cycle");
                    check_value(c_m, eb.beat, "forwarded beat");
                end
            end else if (beat_q.size() != 0) begin
                eb = beat_q[0];
                if (eb.cyc < cyc) begin
                    error_count++;
                    $display("ERROR at %0t: foreign beat was not forwarded", $time);
                    void'(beat_q.pop_front());
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("ERROR: watchdog expired after %0d cycles, errors: %0d",
                 WATCHDOG_CYCLES, error_count);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [1279:0]    fill;
        logic [1279:0]    fill_b;
        logic [KEY_W-1:0] mask;
        logic [31:0]      r;
        int               idx;
        rng_state     = 32'h79184181;
        error_count   = 0;
        model_written = '0;
        for (int i = 0; i < 16; i++) begin
            model_keys[i] = '0;
            model_acts[i] = '0;
        end
        rst_n        = 1'b0;
        key_valid    = 1'b0;
        extract_key  = '0;
        extract_mask = '0;
        phv_in       = '0;
        c_s          = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);

        // empty tables miss even when fully masked
        fill = rand_wide();
        do_lookup(fill[KEY_W-1:0], '0);
        do_lookup(fill[2*KEY_W-1:KEY_W], '1);

        write_keys(8'd5, 3);
        write_actions(8'd5, 2, 1'b0);
        do_lookup(model_keys[5], '0);
        do_lookup(model_keys[6], '0);
        do_lookup(model_keys[7], '0);
        fill = rand_wide();
        fill_b = rand_wide();
        mask = fill[KEY_W-1:0];
        do_lookup(model_keys[6] ^ (fill_b[KEY_W-1:0] & mask), mask);
        // with everything masked entry 5 wins over 6 and 7
        do_lookup(model_keys[7], '1);

        // index 25 wraps to 9 and the trailing odd beat is dropped
        write_actions(8'd25, 2, 1'b1);
        write_keys(8'd9, 3);
        do_lookup(model_keys[9], '0);
        do_lookup(model_keys[10], '0);
        do_lookup(model_keys[11], '0);

        send_foreign(0, 3);
        send_foreign(1, 2);
        send_foreign(2, 4);
        do_lookup(model_keys[5], '0);

        for (int n = 0; n < RANDOM_OPS; n++) begin
            r = next_rand();
            case (r % 4)
                0: write_keys(r[15:8], 1 + next_rand() % 3);
                1: write_actions(r[15:8], 1 + next_rand() % 2, r[16]);
                2: send_foreign(next_rand() % 3, 1 + next_rand() % 3);
                default: begin
                    fill   = rand_wide();
                    fill_b = rand_wide();
                    idx    = r[11:8];
                    // sparse mask of about one bit in four
                    mask = fill[KEY_W-1:0] & fill[2*KEY_W-1:KEY_W];
                    if (r[16]) begin
                        do_lookup(model_keys[idx] ^ (fill_b[KEY_W-1:0] & mask), mask);
                    end else begin
                        do_lookup(fill_b[KEY_W-1:0], mask);
                    end
                end
            endcase
        end

        repeat (8) @(posedge clk);
        if (result_q.size() != 0 || beat_q.size() != 0) begin
            error_count++;
            $display("ERROR: expected outputs still outstanding at the end of the test");
        end
        $display("Checks done, errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
